//--- Makefile
# Verilator build and run of the two-accumulator CPU testbench.
VERILATOR ?= verilator
TOP       ?= twoAccCpuTb
FILELIST  ?= twoAccCpu.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= Result: PASSED

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard hdl/*.sv hdl/*.svh verification/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The run passes only if the simulation output holds the pass message.
run: compile
	@out="$$(./$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

//--- hdl/alu.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module alu import cpuPkg::*; (
  input  logic [`DATA_WIDTH-1:0] aluOper1,
  input  logic [`DATA_WIDTH-1:0] aluOper2,
  input  opcodeT                 aluOpcode,
  output logic [`DATA_WIDTH-1:0] aluData,
  output logic                   carryOut
);

  // Bits of operand 2 that form the shift count.
  localparam int shiftBits = $clog2(`DATA_WIDTH);

  // Operand 1 is always the destination accumulator.
  // Operand 2 is the other accumulator, the constant, or the shift count.
  // Because of that, SUBA gives A - B and SUBB gives B - A.
  always_comb begin
    aluData  = '0;
    carryOut = 1'b0;
    case (aluOpcode)
      // Carry out is the ninth bit of the sum.
      ADDA, ADDB, ADDCA, ADDCB: begin
        {carryOut, aluData} = {1'b0, aluOper1} + {1'b0, aluOper2};
      end
      // Carry out is the borrow of the unsigned difference.
      SUBA, SUBB, SUBCA, SUBCB: begin
        {carryOut, aluData} = {1'b0, aluOper1} - {1'b0, aluOper2};
      end
      ANDA, ANDB, ANDCA, ANDCB: begin
        aluData = aluOper1 & aluOper2;
      end
      ORA, ORB, ORCA, ORCB: begin
        aluData = aluOper1 | aluOper2;
      end
      // Shifts are logical and only apply to A.
      ASLA: begin
        aluData = aluOper1 << aluOper2[shiftBits-1:0];
      end
      ASRA: begin
        aluData = aluOper1 >> aluOper2[shiftBits-1:0];
      end
      // Loads, stores and branches leave the result at zero.
      default: begin
        aluData  = '0;
        carryOut = 1'b0;
      end
    endcase
  end

endmodule

//--- hdl/cpuPkg.sv
`include "cpu_settings.svh"

package cpuPkg;

  // Opcode map of the two-accumulator machine.
  // Values above BBPL are undefined and execute as no-ops.
  typedef enum logic [`OPCODE_WIDTH-1:0] {
    LDA = 6'h00, LDB = 6'h01, LDCA = 6'h02, LDCB = 6'h03,
    STA = 6'h04, STB = 6'h05,
    ADDA = 6'h06, ADDB = 6'h07, ADDCA = 6'h08, ADDCB = 6'h09,
    SUBA = 6'h0A, SUBB = 6'h0B, SUBCA = 6'h0C, SUBCB = 6'h0D,
    ANDA = 6'h0E, ANDB = 6'h0F, ANDCA = 6'h10, ANDCB = 6'h11,
    ORA = 6'h12, ORB = 6'h13, ORCA = 6'h14, ORCB = 6'h15,
    ASLA = 6'h16, ASRA = 6'h17,
    JMP = 6'h18,
    BAEQ = 6'h19, BANE = 6'h1A, BACS = 6'h1B,
    BACC = 6'h1C, BAMI = 6'h1D, BAPL = 6'h1E,
    BBEQ = 6'h1F, BBNE = 6'h20, BBCS = 6'h21,
    BBCC = 6'h22, BBMI = 6'h23, BBPL = 6'h24
  } opcodeT;

  // The operand byte is read two ways.
  // Constant forms and LDCx treat it as an immediate value.
  // Loads, stores, JMP and branches treat it as an address.
  typedef union packed {
    logic [`DATA_WIDTH-1:0] constVal;
    logic [`DATA_WIDTH-1:0] addr;
  } operandT;

  // One instruction word with the opcode in the upper bits.
  typedef struct packed {
    opcodeT  opcode;
    operandT operand;
  } instrT;

  // Branch kinds resolved in execute against A or B.
  typedef enum logic [2:0] {
    brNone,
    brAlways,
    brZero,
    brNotZero,
    brCarrySet,
    brCarryClear,
    brMinus,
    brPlus
  } branchCondT;

endpackage

//--- hdl/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Width of both accumulators, of a data memory byte and of every address.
// Program and data addresses share this width.
`define DATA_WIDTH 8

// Width of the opcode field at the top of the instruction word.
`define OPCODE_WIDTH 6

// Full instruction word with the opcode followed by the 8-bit operand.
`define INSTR_WIDTH 14

// Number of bytes in the internal data memory.
`define MEM_DEPTH 256

`endif

//--- hdl/dataMemory.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module dataMemory (
  input  logic                   clk,
  input  logic [`DATA_WIDTH-1:0] readAddr,
  output logic [`DATA_WIDTH-1:0] readData,
  input  logic                   writeStrobe,
  input  logic [`DATA_WIDTH-1:0] writeAddr,
  input  logic [`DATA_WIDTH-1:0] writeData
);

  // Byte array of the data memory.
  logic [`DATA_WIDTH-1:0] mem [`MEM_DEPTH];

  // Read and write share one clock edge.
  // A load right behind a store to the same byte sees the new value,
  // because the written byte is forwarded to the read register.
  always_ff @(posedge clk) begin
    if (writeStrobe) begin
      mem[writeAddr] <= writeData;
    end
    if (writeStrobe && (writeAddr == readAddr)) begin
      readData <= writeData;
    end else begin
      readData <= mem[readAddr];
    end
  end

  // A store to an unknown address would smear the whole array.
  knownWriteAddr: assert property (
    @(posedge clk) writeStrobe |-> !$isunknown(writeAddr)
  ) else $error("data memory write with unknown address");

endmodule

//--- hdl/decodeStage.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module decodeStage import cpuPkg::*; (
  input  logic                   clk,
  input  logic                   rstN,
  input  instrT                  decIn,
  input  logic                   decValid,
  input  logic                   flush,
  output logic [`DATA_WIDTH-1:0] readAddr,
  output logic                   exValid,
  output opcodeT                 exOpcode,
  output operandT                exOperand,
  output logic                   writeA,
  output logic                   writeB,
  output logic                   useConst,
  output logic                   isLoad,
  output logic                   isStore,
  output logic                   shiftLeft,
  output logic                   shiftRight,
  output branchCondT             branchCond,
  output logic                   branchOnB
);

  // Next values of the execute control levels.
  logic       nWriteA;
  logic       nWriteB;
  logic       nUseConst;
  logic       nIsLoad;
  logic       nIsStore;
  logic       nShiftLeft;
  logic       nShiftRight;
  branchCondT nBranchCond;
  logic       nBranchOnB;
  logic       nDefined;

  // The data memory read starts here so the byte is ready in execute.
  // Every instruction issues a read; only loads consume the result.
  assign readAddr = decIn.operand.addr;

  // Classify the opcode.
  // LDCA and LDCB are loads that take the operand as the value itself.
  always_comb begin
    nWriteA     = 1'b0;
    nWriteB     = 1'b0;
    nUseConst   = 1'b0;
    nIsLoad     = 1'b0;
    nIsStore    = 1'b0;
    nShiftLeft  = 1'b0;
    nShiftRight = 1'b0;
    nBranchCond = brNone;
    nBranchOnB  = 1'b0;
    nDefined    = 1'b1;
    case (decIn.opcode)
      LDA: begin
        nWriteA = 1'b1;
        nIsLoad = 1'b1;
      end
      LDB: begin
        nWriteB = 1'b1;
        nIsLoad = 1'b1;
      end
      LDCA: begin
        nWriteA   = 1'b1;
        nIsLoad   = 1'b1;
        nUseConst = 1'b1;
      end
      LDCB: begin
        nWriteB   = 1'b1;
        nIsLoad   = 1'b1;
        nUseConst = 1'b1;
      end
      STA, STB: nIsStore = 1'b1;
      ADDA, SUBA, ANDA, ORA: nWriteA = 1'b1;
      ADDB, SUBB, ANDB, ORB: nWriteB = 1'b1;
      ADDCA, SUBCA, ANDCA, ORCA: begin
        nWriteA   = 1'b1;
        nUseConst = 1'b1;
      end
      ADDCB, SUBCB, ANDCB, ORCB: begin
        nWriteB   = 1'b1;
        nUseConst = 1'b1;
      end
      ASLA: begin
        nWriteA    = 1'b1;
        nShiftLeft = 1'b1;
      end
      ASRA: begin
        nWriteA     = 1'b1;
        nShiftRight = 1'b1;
      end
      JMP:  nBranchCond = brAlways;
      BAEQ: nBranchCond = brZero;
      BANE: nBranchCond = brNotZero;
      BACS: nBranchCond = brCarrySet;
      BACC: nBranchCond = brCarryClear;
      BAMI: nBranchCond = brMinus;
      BAPL: nBranchCond = brPlus;
      BBEQ, BBNE, BBCS, BBCC, BBMI, BBPL: begin
        nBranchOnB = 1'b1;
        // The B branches sit in the same order as the A branches.
        case (decIn.opcode)
          BBEQ:    nBranchCond = brZero;
          BBNE:    nBranchCond = brNotZero;
          BBCS:    nBranchCond = brCarrySet;
          BBCC:    nBranchCond = brCarryClear;
          BBMI:    nBranchCond = brMinus;
          default: nBranchCond = brPlus;
        endcase
      end
      default: nDefined = 1'b0;
    endcase
  end

  // Control levels for execute.
  // A flush from a taken branch kills the instruction held here.
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      exValid    <= 1'b0;
      writeA     <= 1'b0;
      writeB     <= 1'b0;
      useConst   <= 1'b0;
      isLoad     <= 1'b0;
      isStore    <= 1'b0;
      shiftLeft  <= 1'b0;
      shiftRight <= 1'b0;
      branchCond <= brNone;
      branchOnB  <= 1'b0;
    end else begin
      exValid    <= decValid && !flush && nDefined;
      writeA     <= nWriteA;
      writeB     <= nWriteB;
      useConst   <= nUseConst;
      isLoad     <= nIsLoad;
      isStore    <= nIsStore;
      shiftLeft  <= nShiftLeft;
      shiftRight <= nShiftRight;
      branchCond <= nBranchCond;
      branchOnB  <= nBranchOnB;
    end
  end

  // Opcode and operand are payload that follow the control levels.
  always_ff @(posedge clk) begin
    exOpcode  <= decIn.opcode;
    exOperand <= decIn.operand;
  end

  // Execute picks the alu operands from the destination, so two
  // destinations at once would corrupt an accumulator.
  singleDest: assert property (
    @(posedge clk) disable iff (!rstN)
    !(writeA && writeB)
  ) else $error("both accumulators selected as destination");

endmodule

//--- hdl/executeStage.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module executeStage import cpuPkg::*; (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic                   exValid,
  input  opcodeT                 exOpcode,
  input  operandT                exOperand,
  input  logic                   writeA,
  input  logic                   writeB,
  input  logic                   useConst,
  input  logic                   isLoad,
  input  logic                   isStore,
  input  logic                   shiftLeft,
  input  logic                   shiftRight,
  input  branchCondT             branchCond,
  input  logic                   branchOnB,
  input  logic [`DATA_WIDTH-1:0] readData,
  output logic                   redirect,
  output logic [`DATA_WIDTH-1:0] redirectTarget,
  output logic                   storeStrobe,
  output logic [`DATA_WIDTH-1:0] storeAddr,
  output logic [`DATA_WIDTH-1:0] storeData,
  output logic [`DATA_WIDTH-1:0] accA,
  output logic [`DATA_WIDTH-1:0] accB
);

  // One carry flag per accumulator.
  logic                   carryA;
  logic                   carryB;
  logic [`DATA_WIDTH-1:0] oper1;
  logic [`DATA_WIDTH-1:0] oper2;
  logic [`DATA_WIDTH-1:0] aluData;
  logic                   aluCarry;
  logic [`DATA_WIDTH-1:0] accNext;
  logic                   isAddSub;
  logic [`DATA_WIDTH-1:0] testAcc;
  logic                   testCarry;
  logic                   taken;

  // Operand 1 is the accumulator being written.
  assign oper1 = writeB ? accB : accA;

  // Shifts move by a single bit, so operand 2 carries a count of one.
  always_comb begin
    if (shiftLeft || shiftRight) begin
      oper2 = {{(`DATA_WIDTH-1){1'b0}}, 1'b1};
    end else if (useConst) begin
      oper2 = exOperand.constVal;
    end else if (writeB) begin
      oper2 = accA;
    end else begin
      oper2 = accB;
    end
  end

  alu aluInst (
    .aluOper1 (oper1),
    .aluOper2 (oper2),
    .aluOpcode(exOpcode),
    .aluData  (aluData),
    .carryOut (aluCarry)
  );

  // Memory loads take the byte read during decode.
  // Constant loads take the operand itself.
  assign accNext  = isLoad ? (useConst ? exOperand.constVal : readData) : aluData;
  assign isAddSub = exOpcode inside {ADDA, ADDB, ADDCA, ADDCB, SUBA, SUBB, SUBCA, SUBCB};

  // Accumulators and carries change at the end of the execute cycle.
  // Only ADD and SUB touch the carry of their destination.
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      accA   <= '0;
      accB   <= '0;
      carryA <= 1'b0;
      carryB <= 1'b0;
    end else if (exValid) begin
      if (writeA) begin
        accA <= accNext;
        if (isAddSub) begin
          carryA <= aluCarry;
        end
      end
      if (writeB) begin
        accB <= accNext;
        if (isAddSub) begin
          carryB <= aluCarry;
        end
      end
    end
  end

  // Zero and sign come from the accumulator as it stands right now.
  assign testAcc   = branchOnB ? accB : accA;
  assign testCarry = branchOnB ? carryB : carryA;

  always_comb begin
    case (branchCond)
      brAlways:     taken = 1'b1;
      brZero:       taken = (testAcc == '0);
      brNotZero:    taken = (testAcc != '0);
      brCarrySet:   taken = testCarry;
      brCarryClear: taken = !testCarry;
      brMinus:      taken = testAcc[`DATA_WIDTH-1];
      brPlus:       taken = !testAcc[`DATA_WIDTH-1];
      default:      taken = 1'b0;
    endcase
  end

  // A taken branch flushes fetch and decode at the same edge.
  assign redirect       = exValid && taken;
  assign redirectTarget = exOperand.addr;

  // The store port doubles as the data memory write port.
  assign storeStrobe = exValid && isStore;
  assign storeAddr   = exOperand.addr;
  assign storeData   = (exOpcode == STB) ? accB : accA;

  // One instruction per cycle, so a store never redirects.
  storeNotBranch: assert property (
    @(posedge clk) disable iff (!rstN)
    !(storeStrobe && redirect)
  ) else $error("store and redirect in the same cycle");

endmodule

//--- hdl/fetchStage.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module fetchStage import cpuPkg::*; (
  input  logic                   clk,
  input  logic                   rstN,
  input  instrT                  instr,
  input  logic                   redirect,
  input  logic [`DATA_WIDTH-1:0] redirectTarget,
  output logic [`DATA_WIDTH-1:0] instrAddr,
  output instrT                  decIn,
  output logic                   decValid
);

  // Program counter of the instruction being fetched this cycle.
  logic [`DATA_WIDTH-1:0] pc;

  // The instruction port is combinational, so the PC goes straight out.
  assign instrAddr = pc;

  // A redirect from execute loads the target and kills the word
  // that was fetched from the wrong path in this cycle.
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pc       <= '0;
      decValid <= 1'b0;
    end else if (redirect) begin
      pc       <= redirectTarget;
      decValid <= 1'b0;
    end else begin
      pc       <= pc + 1'b1;
      decValid <= 1'b1;
    end
  end

  // Decode instruction register.
  // Its contents only count when decValid is high.
  always_ff @(posedge clk) begin
    decIn <= instr;
  end

  // After a taken branch the fetch address must be the branch target.
  redirectLoadsPc: assert property (
    @(posedge clk) disable iff (!rstN)
    redirect |=> instrAddr == $past(redirectTarget)
  ) else $error("fetch address does not follow the redirect target");

endmodule

//--- hdl/twoAccCpu.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module twoAccCpu import cpuPkg::*; (
  input  logic                    clk,
  input  logic                    rstN,
  output logic [`DATA_WIDTH-1:0]  instrAddr,
  input  logic [`INSTR_WIDTH-1:0] instr,
  output logic                    storeStrobe,
  output logic [`DATA_WIDTH-1:0]  storeAddr,
  output logic [`DATA_WIDTH-1:0]  storeData,
  output logic [`DATA_WIDTH-1:0]  accA,
  output logic [`DATA_WIDTH-1:0]  accB
);

  // Fetch to decode.
  instrT                  decIn;
  logic                   decValid;
  // Decode to execute.
  logic                   exValid;
  opcodeT                 exOpcode;
  operandT                exOperand;
  logic                   writeA;
  logic                   writeB;
  logic                   useConst;
  logic                   isLoad;
  logic                   isStore;
  logic                   shiftLeft;
  logic                   shiftRight;
  branchCondT             branchCond;
  logic                   branchOnB;
  // Memory read path and branch feedback.
  logic [`DATA_WIDTH-1:0] readAddr;
  logic [`DATA_WIDTH-1:0] readData;
  logic                   redirect;
  logic [`DATA_WIDTH-1:0] redirectTarget;

  // The raw instruction word is laid out exactly as instrT.
  fetchStage fetchInst (
    .clk(clk), .rstN(rstN), .instr(instr), .redirect(redirect),
    .redirectTarget(redirectTarget), .instrAddr(instrAddr),
    .decIn(decIn), .decValid(decValid)
  );

  // A taken branch flushes the instruction sitting in decode.
  decodeStage decodeInst (
    .clk(clk), .rstN(rstN), .decIn(decIn), .decValid(decValid),
    .flush(redirect), .readAddr(readAddr), .exValid(exValid),
    .exOpcode(exOpcode), .exOperand(exOperand), .writeA(writeA),
    .writeB(writeB), .useConst(useConst), .isLoad(isLoad),
    .isStore(isStore), .shiftLeft(shiftLeft), .shiftRight(shiftRight),
    .branchCond(branchCond), .branchOnB(branchOnB)
  );

  // Stores from execute write the data memory directly.
  dataMemory memInst (
    .clk(clk), .readAddr(readAddr), .readData(readData),
    .writeStrobe(storeStrobe), .writeAddr(storeAddr), .writeData(storeData)
  );

  executeStage executeInst (
    .clk(clk), .rstN(rstN), .exValid(exValid), .exOpcode(exOpcode),
    .exOperand(exOperand), .writeA(writeA), .writeB(writeB),
    .useConst(useConst), .isLoad(isLoad), .isStore(isStore),
    .shiftLeft(shiftLeft), .shiftRight(shiftRight), .branchCond(branchCond),
    .branchOnB(branchOnB), .readData(readData), .redirect(redirect),
    .redirectTarget(redirectTarget), .storeStrobe(storeStrobe),
    .storeAddr(storeAddr), .storeData(storeData), .accA(accA), .accB(accB)
  );

endmodule

//--- twoAccCpu.f
+incdir+hdl
hdl/cpuPkg.sv
hdl/fetchStage.sv
hdl/decodeStage.sv
hdl/dataMemory.sv
hdl/alu.sv
hdl/executeStage.sv
hdl/twoAccCpu.sv
verification/twoAccCpuTb.sv

//--- verification/twoAccCpuTb.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module twoAccCpuTb import cpuPkg::*; ();

  localparam int maxTests = 16;

  logic                    clk = 1'b0;
  logic                    rstN = 1'b1;
  logic [`DATA_WIDTH-1:0]  instrAddr;
  logic [`INSTR_WIDTH-1:0] instr;
  logic                    storeStrobe;
  logic [`DATA_WIDTH-1:0]  storeAddr;
  logic [`DATA_WIDTH-1:0]  storeData;
  logic [`DATA_WIDTH-1:0]  accA;
  logic [`DATA_WIDTH-1:0]  accB;

  // Program ROM and the table of expected stores, indexed by address.
  logic [`INSTR_WIDTH-1:0] rom [`MEM_DEPTH];
  logic                    expUsed [`MEM_DEPTH];
  logic [`DATA_WIDTH-1:0]  expVal [`MEM_DEPTH];
  // Per test the closing store address, the store count and the name.
  logic [`DATA_WIDTH-1:0]  finalAddr [maxTests];
  int                      wantStores [maxTests];
  string                   testName [maxTests];
  // Accumulator contents expected while each closing store executes.
  logic [`DATA_WIDTH-1:0]  finalA [maxTests];
  logic [`DATA_WIDTH-1:0]  finalB [maxTests];
  logic [`DATA_WIDTH-1:0]  modelA;
  logic [`DATA_WIDTH-1:0]  modelB;
  int progLen = 0;
  int numTests = 0;
  int testsDone = 0;
  int storesSeen = 0;
  int errorCount = 0;
  int testErrorBase = 0;
  int failedTests = 0;
  int cycles = 0;
  int cycleLimit = 0;
  logic                    timedOut;
  logic [31:0]             rngState;
  logic [`DATA_WIDTH-1:0]  x;
  logic [`DATA_WIDTH-1:0]  y;

  twoAccCpu UUT (
    .clk(clk), .rstN(rstN), .instrAddr(instrAddr), .instr(instr),
    .storeStrobe(storeStrobe), .storeAddr(storeAddr), .storeData(storeData),
    .accA(accA), .accB(accB)
  );

  always #4 clk = ~clk;

  // The instruction port is answered in the same cycle.
  assign instr = rom[instrAddr];

  // Linear congruential generator for the test constants.
  function automatic logic [31:0] nextRandom(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  // Unused ROM words hold an undefined opcode, so they run as no-ops.
  // Both accumulators leave reset at zero.
  task automatic clearTables();
    for (int i = 0; i < `MEM_DEPTH; i++) begin
      rom[i]     = {6'h3F, 8'(i)};
      expUsed[i] = 1'b0;
      expVal[i]  = '0;
    end
    for (int i = 0; i < maxTests; i++) begin
      wantStores[i] = 0;
    end
    modelA = '0;
    modelB = '0;
  endtask

  task automatic placeInstr(input opcodeT op, input logic [7:0] operand);
    rom[progLen] = {op, operand};
    progLen++;
  endtask

  task automatic expectStore(input logic [7:0] addr, input logic [7:0] value);
    expUsed[addr] = 1'b1;
    expVal[addr]  = value;
    wantStores[numTests]++;
  endtask

  task automatic closeTest(input string name, input logic [7:0] addr);
    testName[numTests]  = name;
    finalAddr[numTests] = addr;
    finalA[numTests]    = modelA;
    finalB[numTests]    = modelB;
    numTests++;
  endtask

  // Carry is bit 8 of the sum, and bit 8 of the difference is the borrow.
  // BACS skips its store on a carry; BBCC skips its store without a borrow.
  task automatic carryCase(input string name, input logic [7:0] a, input logic [7:0] b,
                           input logic [7:0] base);
    logic [8:0] sum;
    logic [8:0] diff;
    sum  = {1'b0, a} + {1'b0, b};
    diff = {1'b0, b} - {1'b0, a};
    placeInstr(LDCA, a);
    placeInstr(LDCB, b);
    placeInstr(ADDA, 8'h00);
    placeInstr(BACS, 8'(progLen + 2));
    placeInstr(STA, base);
    if (!sum[8]) expectStore(base, sum[7:0]);
    placeInstr(STA, base + 8'd1);
    expectStore(base + 8'd1, sum[7:0]);
    placeInstr(SUBCB, a);
    placeInstr(BBCC, 8'(progLen + 2));
    placeInstr(STB, base + 8'd2);
    if (diff[8]) expectStore(base + 8'd2, diff[7:0]);
    placeInstr(STB, base + 8'd3);
    expectStore(base + 8'd3, diff[7:0]);
    modelA = sum[7:0];
    modelB = diff[7:0];
    closeTest(name, base + 8'd3);
  endtask

  // A store right after the branch is expected only when it falls through.
  task automatic branchCase(input string name, input opcodeT op, input logic onB,
                            input logic [7:0] value, input logic taken,
                            input logic [7:0] base);
    opcodeT loadOp;
    opcodeT storeOp;
    loadOp  = onB ? LDCB : LDCA;
    storeOp = onB ? STB : STA;
    placeInstr(loadOp, value);
    placeInstr(op, 8'(progLen + 2));
    placeInstr(storeOp, base);
    if (!taken) expectStore(base, value);
    placeInstr(storeOp, base + 8'd1);
    expectStore(base + 8'd1, value);
    if (onB) begin
      modelB = value;
    end else begin
      modelA = value;
    end
    closeTest(name, base + 8'd1);
  endtask

  task automatic buildProgram();
    logic [7:0] negVal;
    negVal = y | 8'h80;
    // Arithmetic and logic, each result stored at its own address.
    placeInstr(LDCA, x);
    placeInstr(LDCB, y);
    placeInstr(ADDA, 8'h00);
    placeInstr(STA, 8'h10);
    expectStore(8'h10, 8'(x + y));
    placeInstr(SUBCB, x);
    placeInstr(STB, 8'h11);
    expectStore(8'h11, 8'(y - x));
    placeInstr(LDCA, x);
    placeInstr(ANDCA, y);
    placeInstr(STA, 8'h12);
    expectStore(8'h12, x & y);
    placeInstr(LDCB, x);
    placeInstr(ORCB, y);
    placeInstr(STB, 8'h13);
    expectStore(8'h13, x | y);
    placeInstr(LDCA, x);
    placeInstr(ASLA, 8'h00);
    placeInstr(STA, 8'h14);
    expectStore(8'h14, {x[6:0], 1'b0});
    placeInstr(ASRA, 8'h00);
    placeInstr(STA, 8'h15);
    expectStore(8'h15, {1'b0, x[6:0]});
    modelA = {1'b0, x[6:0]};
    modelB = x | y;
    closeTest("alu", 8'h15);
    // The complemented pair flips the carry outcome in most cases.
    carryCase("carry", x, y, 8'h20);
    carryCase("carry inverted", ~x, ~y, 8'h24);
    branchCase("BAEQ", BAEQ, 1'b0, 8'h00, 8'h00 == 8'h00, 8'h30);
    branchCase("BANE", BANE, 1'b0, 8'h00, 8'h00 != 8'h00, 8'h32);
    branchCase("BBMI", BBMI, 1'b1, negVal, negVal[7], 8'h34);
    branchCase("BBPL", BBPL, 1'b1, negVal, !negVal[7], 8'h36);
    // The load reads the byte in the same cycle that the store writes it.
    placeInstr(LDCA, x);
    placeInstr(STA, 8'h40);
    expectStore(8'h40, x);
    placeInstr(LDB, 8'h40);
    placeInstr(STB, 8'h41);
    expectStore(8'h41, x);
    modelA = x;
    modelB = x;
    closeTest("store then load", 8'h41);
    // Both words behind the jump store to addresses that no test expects.
    placeInstr(JMP, 8'(progLen + 3));
    placeInstr(STA, 8'hEE);
    placeInstr(STA, 8'hEF);
    placeInstr(LDCA, y);
    placeInstr(STA, 8'h50);
    expectStore(8'h50, y);
    modelA = y;
    closeTest("jump", 8'h50);
    // Park the CPU in a loop on itself.
    placeInstr(JMP, 8'(progLen));
  endtask

  // Fetch must sit at address zero and stay quiet through reset.
  resetQuiet: assert property (
    @(posedge clk) (!rstN || $rose(rstN)) |-> (instrAddr == '0 && !storeStrobe)
  ) else begin
    errorCount++;
    $display("FAIL %0t: fetch address %02h or store strobe %b not idle in reset",
             $time, $sampled(instrAddr), $sampled(storeStrobe));
  end

  // Every store must go to an expected address with the expected byte.
  storeCheck: assert property (
    @(posedge clk) disable iff (!rstN)
    storeStrobe |-> (expUsed[storeAddr] && storeData == expVal[storeAddr])
  ) else begin
    errorCount++;
    if (!expUsed[$sampled(storeAddr)]) begin
      $display("FAIL %0t: store to address %02h, which no test expects",
               $time, $sampled(storeAddr));
    end else begin
      $display("FAIL %0t: store to %02h wrote %02h, expected %02h", $time,
               $sampled(storeAddr), $sampled(storeData), expVal[$sampled(storeAddr)]);
    end
  end

  // Stores are counted on the falling edge, where the port is stable.
  // A test ends at its closing store; a skipped fall-through store shows as a short count.
  // The store check of the closing store reports at the next rising edge,
  // so the line for the test waits until just after that edge.
  always @(negedge clk) begin
    if (rstN && storeStrobe && testsDone < numTests) begin
      storesSeen++;
      if (storeAddr == finalAddr[testsDone]) begin
        storeCount: assert (storesSeen == wantStores[testsDone]) else begin
          errorCount++;
          $display("Test %s ran %0d stores but %0d were due", testName[testsDone],
                   storesSeen, wantStores[testsDone]);
        end
        accCheck: assert (accA == finalA[testsDone] && accB == finalB[testsDone]) else begin
          errorCount++;
          $display("FAIL %0t: test %s left A %02h and B %02h, expected %02h and %02h",
                   $time, testName[testsDone], accA, accB, finalA[testsDone],
                   finalB[testsDone]);
        end
        @(posedge clk);
        #1;
        if (errorCount != testErrorBase) failedTests++;
        $display("test %0d %s done with %0d errors", testsDone + 1, testName[testsDone],
                 errorCount - testErrorBase);
        testErrorBase = errorCount;
        storesSeen = 0;
        testsDone++;
      end
    end
  end

  initial begin
    clearTables();
    rngState = 32'd32608;
    rngState = nextRandom(rngState);
    x = rngState[23:16];
    rngState = nextRandom(rngState);
    y = rngState[23:16];
    buildProgram();
    // Each instruction plus a worst case of two flushed slots, and some slack.
    cycleLimit = 3 * progLen + 50;
    #1 rstN = 1'b0;
    repeat (5) @(posedge clk);
    #1 rstN = 1'b1;
    @(posedge clk);
    #1;
    if (errorCount != 0) failedTests++;
    $display("test 0 reset done with %0d errors", errorCount);
    testErrorBase = errorCount;
    while (testsDone < numTests && cycles < cycleLimit) begin
      @(posedge clk);
      cycles++;
    end
    timedOut = (testsDone < numTests);
    if (timedOut) begin
      $display("Timeout: after %0d cycles only %0d of %0d tests had finished",
               cycles, testsDone, numTests);
    end
    // A few idle cycles let any late store reach the checks.
    repeat (4) @(posedge clk);
    $display("Tests run %0d, tests with errors %0d, errors %0d",
             numTests + 1, failedTests, errorCount);
    if (errorCount == 0 && !timedOut) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule
